// ==== filelist.f ====
verilog/dmem_pkg.sv
verilog/port_arbiter.sv
verilog/stride_agu.sv
verilog/dmem_array.sv
verilog/dmem_top.sv
verif/dmem_asserts.sv
verif/dmem_tb.sv

// ==== verif/dmem_asserts.sv ====
// Bound to dmem_top and checks the requester protocol only while reset is low
module dmem_asserts #(
	parameter int ADDR_WIDTH	= dmem_pkg::DEFAULT_ADDR_WIDTH
) (
	input	logic						clock,
	input	logic						reset,
	input	logic						stall,
	input	logic						st_grant1,
	input	logic						st_grant2,
	input	logic						ld_grant1,
	input	logic						ld_grant2,
	input	logic						st_ready1,
	input	logic						st_ready2,
	input	logic						ld_ready1,
	input	logic						ld_ready2,
	input	logic						ld_valid1,
	input	logic						ld_valid2,
	input	logic						ld_data_valid1,
	input	logic						ld_data_valid2,
	input	logic	[ADDR_WIDTH-1:0]	st_length1,
	input	logic	[ADDR_WIDTH-1:0]	st_length2,
	input	logic	[ADDR_WIDTH-1:0]	ld_length1,
	input	logic	[ADDR_WIDTH-1:0]	ld_length2
);
	timeunit 1ns;
	timeprecision 1ns;

	logic	ld_accept1;
	logic	ld_accept2;
	int		failures = 0;		// Failed assertion count

	assign ld_accept1	= ld_ready1 & ld_valid1 & ~stall;
	assign ld_accept2	= ld_ready2 & ld_valid2 & ~stall;

	////////////////////////////////////////////////////////////
	// Grant and ready
	////////////////////////////////////////////////////////////

	one_store_grant: assert property ( @( posedge clock ) disable iff ( reset )
		!( st_grant1 && st_grant2 ) ) else begin
		$error( "two store grants at once" );
		failures++;
	end
	one_load_grant: assert property ( @( posedge clock ) disable iff ( reset )
		!( ld_grant1 && ld_grant2 ) ) else begin
		$error( "two load grants at once" );
		failures++;
	end
	ready_needs_grant: assert property ( @( posedge clock ) disable iff ( reset )
		( !st_ready1 || st_grant1 ) && ( !st_ready2 || st_grant2 )
		&& ( !ld_ready1 || ld_grant1 ) && ( !ld_ready2 || ld_grant2 ) ) else begin
		$error( "ready without grant" );
		failures++;
	end

	////////////////////////////////////////////////////////////
	// Load return and descriptor
	////////////////////////////////////////////////////////////

	// Data valid is exactly the accepted beat one cycle later
	load_return: assert property ( @( posedge clock ) disable iff ( reset )
		( ld_data_valid1 == $past( ld_accept1 ) )
		&& ( ld_data_valid2 == $past( ld_accept2 ) ) ) else begin
		$error( "load data valid out of step with accepted beat" );
		failures++;
	end
	nonzero_length: assert property ( @( posedge clock ) disable iff ( reset )
		( !$rose( st_grant1 ) || st_length1 != '0 )
		&& ( !$rose( st_grant2 ) || st_length2 != '0 )
		&& ( !$rose( ld_grant1 ) || ld_length1 != '0 )
		&& ( !$rose( ld_grant2 ) || ld_length2 != '0 ) ) else begin
		$error( "grant issued for a zero length transfer" );
		failures++;
	end

endmodule

bind dmem_top dmem_asserts #( .ADDR_WIDTH( ADDR_WIDTH ) ) dmem_asserts_i ( .* );

// ==== verif/dmem_tb.sv ====
// Runs default widths only and never compares a load of a word that no store has written yet
module dmem_tb;
	timeunit 1ns;
	timeprecision 1ns;
	import dmem_pkg::*;

	localparam int AW			= DEFAULT_ADDR_WIDTH;
	localparam int DW			= DEFAULT_DATA_WIDTH;
	localparam int TRANSFERS	= 12;		// Per requester
	localparam int DRIVE_DELAY	= 10;
	localparam int WATCHDOG_NS	= 4 * TRANSFERS * 40 * 100;

	logic				clock;
	logic				reset;
	logic				stall;
	logic				st_req[1:2], ld_req[1:2], st_valid[1:2], ld_valid[1:2];
	logic	[AW-1:0]	st_length[1:2], st_stride[1:2], st_base[1:2];
	logic	[AW-1:0]	ld_length[1:2], ld_stride[1:2], ld_base[1:2];
	logic	[DW-1:0]	st_data[1:2], ld_data[1:2];
	logic				st_grant[1:2], ld_grant[1:2], st_ready[1:2], ld_ready[1:2];
	logic				ld_data_valid[1:2];

	logic	[DW-1:0]	ref_mem[2**AW];		// Reference memory
	bit					written[2**AW];
	logic	[31:0]		lfsr_state = 32'h0c6c_8145;
	int					errors = 0;

	dmem_top dmem_top_i (
		.clock( clock ), .reset( reset ), .stall( stall ),
		.st_req1( st_req[1] ), .st_req2( st_req[2] ), .ld_req1( ld_req[1] ), .ld_req2( ld_req[2] ),
		.st_length1( st_length[1] ), .st_stride1( st_stride[1] ), .st_base1( st_base[1] ),
		.st_length2( st_length[2] ), .st_stride2( st_stride[2] ), .st_base2( st_base[2] ),
		.ld_length1( ld_length[1] ), .ld_stride1( ld_stride[1] ), .ld_base1( ld_base[1] ),
		.ld_length2( ld_length[2] ), .ld_stride2( ld_stride[2] ), .ld_base2( ld_base[2] ),
		.st_valid1( st_valid[1] ), .st_valid2( st_valid[2] ),
		.ld_valid1( ld_valid[1] ), .ld_valid2( ld_valid[2] ),
		.st_data1( st_data[1] ), .st_data2( st_data[2] ),
		.st_grant1( st_grant[1] ), .st_grant2( st_grant[2] ),
		.ld_grant1( ld_grant[1] ), .ld_grant2( ld_grant[2] ),
		.st_ready1( st_ready[1] ), .st_ready2( st_ready[2] ),
		.ld_ready1( ld_ready[1] ), .ld_ready2( ld_ready[2] ),
		.ld_data1( ld_data[1] ), .ld_data2( ld_data[2] ),
		.ld_data_valid1( ld_data_valid[1] ), .ld_data_valid2( ld_data_valid[2] )
	);

	always #50 clock = ~clock;

	////////////////////////////////////////////////////////////
	// Random source and checks
	////////////////////////////////////////////////////////////

	// Taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = { lfsr_state[30:0], fb };
		return fb;
	endfunction

	function automatic logic [31:0] random_bits( input int n );
		logic [31:0] value;
		value = '0;
		for ( int b = 0; b < n; b++ ) begin
			value = { value[30:0], lfsr_step() };
		end
		return value;
	endfunction

	task automatic check_value( input string name, input logic [31:0] got,
			input logic [31:0] expected );
		assert ( got === expected ) else begin
			$display( "** Error: %s is %h, expected %h at %0t ns", name, got, expected, $time );
			errors++;
		end
	endtask

	task automatic check_return( input int k, input bit pend, input logic [DW-1:0] word,
			input bit known );
		check_value( $sformatf( "ld_data_valid%0d", k ), ld_data_valid[k], pend );
		if ( pend && known ) begin
			check_value( $sformatf( "ld_data%0d", k ), ld_data[k], word );
		end
		else if ( !pend ) begin
			check_value( $sformatf( "ld_data%0d", k ), ld_data[k], '0 );		// Not the owner
		end
	endtask

	////////////////////////////////////////////////////////////
	// Requesters
	////////////////////////////////////////////////////////////

	// Small stride and a base near the top keep addresses wrapping and overlapping
	task automatic pick_descriptor( output logic [AW-1:0] len, str, bas );
		len = AW'( random_bits( 3 ) ) + AW'( 1 );
		str = AW'( random_bits( 3 ) );
		bas = AW'( random_bits( 5 ) ) + AW'( 'he8 );
	endtask

	task automatic store_requester( input int k );
		logic [AW-1:0] len, str, bas, addr;
		bit accepted;
		int i;
		for ( int t = 0; t < TRANSFERS; t++ ) begin
			repeat ( random_bits( 2 ) ) @( posedge clock );
			pick_descriptor( len, str, bas );
			@( posedge clock );
			#DRIVE_DELAY;
			{ st_length[k], st_stride[k], st_base[k], st_req[k] } = { len, str, bas, 1'b1 };
			i = 0;
			while ( i < len ) begin
				st_valid[k]	= ( random_bits( 2 ) != 0 );		// Gap one beat in four
				st_data[k]	= random_bits( 32 );
				@( negedge clock );
				if ( i > 0 ) check_value( $sformatf( "st_grant%0d", k ), st_grant[k], 1 );
				accepted	= st_ready[k] & st_valid[k] & ~stall;
				addr		= bas + AW'( i ) * str;
				@( posedge clock );
				if ( accepted ) begin
					ref_mem[addr]	= st_data[k];		// Written at this edge
					written[addr]	= 1'b1;
					i++;
				end
				#DRIVE_DELAY;
			end
			{ st_req[k], st_valid[k] } = 2'b00;
			@( negedge clock );
			check_value( $sformatf( "st_grant%0d", k ), st_grant[k], 0 );
		end
	endtask

	task automatic load_requester( input int k );
		logic [AW-1:0] len, str, bas, addr;
		logic [DW-1:0] word;
		bit accepted, pend, known;
		int i;
		pend = 1'b0;
		for ( int t = 0; t < TRANSFERS; t++ ) begin
			repeat ( random_bits( 2 ) ) @( posedge clock );
			pick_descriptor( len, str, bas );
			@( posedge clock );
			#DRIVE_DELAY;
			{ ld_length[k], ld_stride[k], ld_base[k], ld_req[k] } = { len, str, bas, 1'b1 };
			i = 0;
			while ( i < len ) begin
				ld_valid[k]	= ( random_bits( 2 ) != 0 );
				@( negedge clock );
				check_return( k, pend, word, known );
				if ( i > 0 ) check_value( $sformatf( "ld_grant%0d", k ), ld_grant[k], 1 );
				accepted	= ld_ready[k] & ld_valid[k] & ~stall;
				pend		= accepted;
				if ( accepted ) begin
					addr	= bas + AW'( i ) * str;
					word	= ref_mem[addr];		// Old word if stored this edge
					known	= written[addr];
					i++;
				end
				@( posedge clock );
				#DRIVE_DELAY;
			end
			{ ld_req[k], ld_valid[k] } = 2'b00;
			@( negedge clock );
			check_return( k, pend, word, known );
			check_value( $sformatf( "ld_grant%0d", k ), ld_grant[k], 0 );
			pend = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stall, arbitration order, watchdog
	////////////////////////////////////////////////////////////

	task automatic drive_stall();
		forever begin
			@( posedge clock );
			#DRIVE_DELAY;
			stall = ( random_bits( 3 ) == 0 );		// About one cycle in eight
		end
	endtask

	// Requests at the previous falling edge are the ones the arbiter sampled
	task automatic watch_arbiter( input bit load_side );
		logic g1, g2, r1, r2, prev_g, prev_r1, prev_r2;
		int last;
		{ last, prev_g, prev_r1, prev_r2 } = { 32'd2, 3'b000 };		// Requester 1 first
		forever begin
			@( negedge clock );
			g1 = load_side ? ld_grant[1] : st_grant[1];
			g2 = load_side ? ld_grant[2] : st_grant[2];
			r1 = load_side ? ld_req[1] : st_req[1];
			r2 = load_side ? ld_req[2] : st_req[2];
			if ( ( g1 | g2 ) && !prev_g ) begin
				if ( prev_r1 && prev_r2 ) begin
					check_value( load_side ? "{ld_grant2, ld_grant1}" : "{st_grant2, st_grant1}",
						{ g2, g1 }, ( last == 1 ) ? 2'b10 : 2'b01 );
				end
				last = g1 ? 1 : 2;
			end
			{ prev_g, prev_r1, prev_r2 } = { g1 | g2, r1, r2 };
		end
	endtask

	initial begin
		#WATCHDOG_NS;
		$display( "Timeout: transfers still running after %0d ns, %0d errors so far",
			WATCHDOG_NS, errors + dmem_top_i.dmem_asserts_i.failures );
		$display( "Finished with errors" );
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		{ clock, reset, stall } = 3'b010;
		for ( int k = 1; k <= 2; k++ ) begin
			{ st_req[k], ld_req[k], st_valid[k], ld_valid[k] } = 4'b0000;
			{ st_length[k], st_stride[k], st_base[k], st_data[k] } = '0;
			{ ld_length[k], ld_stride[k], ld_base[k] } = '0;
		end
		repeat ( 4 ) @( posedge clock );
		@( negedge clock );
		for ( int k = 1; k <= 2; k++ ) begin
			check_value( $sformatf( "st_grant%0d", k ), st_grant[k], 0 );
			check_value( $sformatf( "ld_grant%0d", k ), ld_grant[k], 0 );
			check_value( $sformatf( "st_ready%0d", k ), st_ready[k], 0 );
			check_value( $sformatf( "ld_ready%0d", k ), ld_ready[k], 0 );
			check_value( $sformatf( "ld_data_valid%0d", k ), ld_data_valid[k], 0 );
		end
		@( posedge clock );		// Fifth edge in reset
		#DRIVE_DELAY;
		reset = 1'b0;
		fork
			drive_stall();
			watch_arbiter( 1'b0 );
			watch_arbiter( 1'b1 );
		join_none
		fork
			store_requester( 1 );
			store_requester( 2 );
			load_requester( 1 );
			load_requester( 2 );
		join
		repeat ( 2 ) @( posedge clock );
		$display( "Run complete: %0d transfers, %0d check errors, %0d assertion failures",
			4 * TRANSFERS, errors, dmem_top_i.dmem_asserts_i.failures );
		if ( errors == 0 && dmem_top_i.dmem_asserts_i.failures == 0 ) begin
			$display( "Finished with no errors" );
		end
		else begin
			$display( "Finished with errors" );
		end
		$finish;
	end

endmodule

// ==== verilog/dmem_array.sv ====
// Memory has no reset and a read and write to one address in the same cycle returns the old word
module dmem_array #(
	parameter int ADDR_WIDTH	= dmem_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH	= dmem_pkg::DEFAULT_DATA_WIDTH
) (
	input	logic						clock,
	input	logic						reset,
	input	logic						st_beat,		// Write strobe
	input	logic	[ADDR_WIDTH-1:0]	st_address,
	input	logic						st_grant1,		// Selects store data 1
	input	logic	[DATA_WIDTH-1:0]	st_data1,
	input	logic	[DATA_WIDTH-1:0]	st_data2,
	input	logic						ld_beat,		// Read strobe
	input	logic	[ADDR_WIDTH-1:0]	ld_address,
	input	logic						ld_grant1,		// Owner of the read beat
	output	logic	[DATA_WIDTH-1:0]	ld_data1,
	output	logic	[DATA_WIDTH-1:0]	ld_data2,
	output	logic						ld_data_valid1,
	output	logic						ld_data_valid2
);

	localparam int DEPTH	= 2 ** ADDR_WIDTH;

	logic	[DATA_WIDTH-1:0]	mem	[DEPTH];
	logic	[DATA_WIDTH-1:0]	st_data;
	logic	[DATA_WIDTH-1:0]	rd_data;		// Registered read word
	logic						rd_valid;
	logic						rd_owner1;		// Read beat belonged to requester 1

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////

	// Grant 2 is implied whenever a beat runs without grant 1
	assign st_data	= ( st_grant1 ) ? st_data1 : st_data2;

	always_ff @( posedge clock ) begin
		if ( st_beat ) begin
			mem[ st_address ]	<= st_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( ld_beat ) begin
			rd_data		<= mem[ ld_address ];	// Sees the word before this edge's write
		end
	end

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			rd_valid	<= 1'b0;
			rd_owner1	<= 1'b0;
		end
		else begin
			rd_valid	<= ld_beat;
			if ( ld_beat ) begin
				rd_owner1	<= ld_grant1;
			end
		end
	end

	// Steering to the owner, zero on the other side
	assign ld_data_valid1	= rd_valid & rd_owner1;
	assign ld_data_valid2	= rd_valid & ~rd_owner1;

	assign ld_data1			= ( ld_data_valid1 ) ? rd_data : '0;
	assign ld_data2			= ( ld_data_valid2 ) ? rd_data : '0;

endmodule

// ==== verilog/dmem_pkg.sv ====
// Widths here are only defaults and dmem_top may override both of them
package dmem_pkg;

	////////////////////////////////////////////////////////////
	// Default widths
	////////////////////////////////////////////////////////////

	// Address, length and stride share one width
	parameter int DEFAULT_ADDR_WIDTH	= 8;		// 256 words
	parameter int DEFAULT_DATA_WIDTH	= 32;		// One memory word

	////////////////////////////////////////////////////////////
	// State encodings
	////////////////////////////////////////////////////////////

	// Arbiter holds a grant from issue until the generator ends the transfer
	typedef enum logic {
		ARB_IDLE	= 1'b0,		// No grant held
		ARB_BUSY	= 1'b1		// Grant held until done
	} arb_state_e;

	// Generator walks the strided addresses of one transfer
	typedef enum logic {
		AGU_IDLE	= 1'b0,		// Waiting for start
		AGU_RUN		= 1'b1		// Accepting beats
	} agu_state_e;

endpackage

// ==== verilog/dmem_top.sv ====
// Length zero is unsupported and memory contents are undefined until written
module dmem_top #(
	parameter int ADDR_WIDTH	= dmem_pkg::DEFAULT_ADDR_WIDTH,
	parameter int DATA_WIDTH	= dmem_pkg::DEFAULT_DATA_WIDTH
) (
	input	logic						clock,
	input	logic						reset,
	input	logic						stall,			// Freezes both channels
	input	logic						st_req1,
	input	logic						st_req2,
	input	logic						ld_req1,
	input	logic						ld_req2,
	input	logic	[ADDR_WIDTH-1:0]	st_length1,
	input	logic	[ADDR_WIDTH-1:0]	st_stride1,
	input	logic	[ADDR_WIDTH-1:0]	st_base1,
	input	logic	[ADDR_WIDTH-1:0]	st_length2,
	input	logic	[ADDR_WIDTH-1:0]	st_stride2,
	input	logic	[ADDR_WIDTH-1:0]	st_base2,
	input	logic	[ADDR_WIDTH-1:0]	ld_length1,
	input	logic	[ADDR_WIDTH-1:0]	ld_stride1,
	input	logic	[ADDR_WIDTH-1:0]	ld_base1,
	input	logic	[ADDR_WIDTH-1:0]	ld_length2,
	input	logic	[ADDR_WIDTH-1:0]	ld_stride2,
	input	logic	[ADDR_WIDTH-1:0]	ld_base2,
	input	logic						st_valid1,
	input	logic						st_valid2,
	input	logic						ld_valid1,
	input	logic						ld_valid2,
	input	logic	[DATA_WIDTH-1:0]	st_data1,
	input	logic	[DATA_WIDTH-1:0]	st_data2,
	output	logic						st_grant1,
	output	logic						st_grant2,
	output	logic						ld_grant1,
	output	logic						ld_grant2,
	output	logic						st_ready1,
	output	logic						st_ready2,
	output	logic						ld_ready1,
	output	logic						ld_ready2,
	output	logic	[DATA_WIDTH-1:0]	ld_data1,
	output	logic	[DATA_WIDTH-1:0]	ld_data2,
	output	logic						ld_data_valid1,
	output	logic						ld_data_valid2
);

	// Store channel
	logic						st_start;
	logic						st_done;
	logic						st_beat;
	logic	[ADDR_WIDTH-1:0]	st_length;
	logic	[ADDR_WIDTH-1:0]	st_stride;
	logic	[ADDR_WIDTH-1:0]	st_base;
	logic	[ADDR_WIDTH-1:0]	st_address;

	// Load channel
	logic						ld_start;
	logic						ld_done;
	logic						ld_beat;
	logic	[ADDR_WIDTH-1:0]	ld_length;
	logic	[ADDR_WIDTH-1:0]	ld_stride;
	logic	[ADDR_WIDTH-1:0]	ld_base;
	logic	[ADDR_WIDTH-1:0]	ld_address;

	////////////////////////////////////////////////////////////
	// Store side
	////////////////////////////////////////////////////////////

	port_arbiter #(
		.ADDR_WIDTH(	ADDR_WIDTH	)
	) store_arb (
		.clock(		clock		),
		.reset(		reset		),
		.req1(		st_req1		),
		.req2(		st_req2		),
		.length1(	st_length1	),
		.stride1(	st_stride1	),
		.base1(		st_base1	),
		.length2(	st_length2	),
		.stride2(	st_stride2	),
		.base2(		st_base2	),
		.done(		st_done		),
		.grant1(	st_grant1	),
		.grant2(	st_grant2	),
		.start(		st_start	),
		.length(	st_length	),
		.stride(	st_stride	),
		.base(		st_base		)
	);

	stride_agu #(
		.ADDR_WIDTH(	ADDR_WIDTH	)
	) store_agu (
		.clock(		clock		),
		.reset(		reset		),
		.start(		st_start	),
		.length(	st_length	),
		.stride(	st_stride	),
		.base(		st_base		),
		.grant1(	st_grant1	),
		.grant2(	st_grant2	),
		.valid1(	st_valid1	),
		.valid2(	st_valid2	),
		.stall(		stall		),
		.ready1(	st_ready1	),
		.ready2(	st_ready2	),
		.address(	st_address	),
		.beat(		st_beat		),
		.done(		st_done		)
	);

	////////////////////////////////////////////////////////////
	// Load side
	////////////////////////////////////////////////////////////

	port_arbiter #(
		.ADDR_WIDTH(	ADDR_WIDTH	)
	) load_arb (
		.clock(		clock		),
		.reset(		reset		),
		.req1(		ld_req1		),
		.req2(		ld_req2		),
		.length1(	ld_length1	),
		.stride1(	ld_stride1	),
		.base1(		ld_base1	),
		.length2(	ld_length2	),
		.stride2(	ld_stride2	),
		.base2(		ld_base2	),
		.done(		ld_done		),
		.grant1(	ld_grant1	),
		.grant2(	ld_grant2	),
		.start(		ld_start	),
		.length(	ld_length	),
		.stride(	ld_stride	),
		.base(		ld_base		)
	);

	stride_agu #(
		.ADDR_WIDTH(	ADDR_WIDTH	)
	) load_agu (
		.clock(		clock		),
		.reset(		reset		),
		.start(		ld_start	),
		.length(	ld_length	),
		.stride(	ld_stride	),
		.base(		ld_base		),
		.grant1(	ld_grant1	),
		.grant2(	ld_grant2	),
		.valid1(	ld_valid1	),
		.valid2(	ld_valid2	),
		.stall(		stall		),
		.ready1(	ld_ready1	),
		.ready2(	ld_ready2	),
		.address(	ld_address	),
		.beat(		ld_beat		),
		.done(		ld_done		)
	);

	////////////////////////////////////////////////////////////
	// Shared storage
	////////////////////////////////////////////////////////////

	dmem_array #(
		.ADDR_WIDTH(	ADDR_WIDTH	),
		.DATA_WIDTH(	DATA_WIDTH	)
	) dmem_array (
		.clock(				clock			),
		.reset(				reset			),
		.st_beat(			st_beat			),
		.st_address(		st_address		),
		.st_grant1(			st_grant1		),
		.st_data1(			st_data1		),
		.st_data2(			st_data2		),
		.ld_beat(			ld_beat			),
		.ld_address(		ld_address		),
		.ld_grant1(			ld_grant1		),
		.ld_data1(			ld_data1		),
		.ld_data2(			ld_data2		),
		.ld_data_valid1(	ld_data_valid1	),
		.ld_data_valid2(	ld_data_valid2	)
	);

endmodule

// ==== verilog/port_arbiter.sv ====
// Requesters must hold their descriptor stable while req is high and drop req when grant falls
module port_arbiter #(
	parameter int ADDR_WIDTH	= dmem_pkg::DEFAULT_ADDR_WIDTH
) (
	input	logic						clock,
	input	logic						reset,
	input	logic						req1,		// Requester 1 level
	input	logic						req2,		// Requester 2 level
	input	logic	[ADDR_WIDTH-1:0]	length1,
	input	logic	[ADDR_WIDTH-1:0]	stride1,
	input	logic	[ADDR_WIDTH-1:0]	base1,
	input	logic	[ADDR_WIDTH-1:0]	length2,
	input	logic	[ADDR_WIDTH-1:0]	stride2,
	input	logic	[ADDR_WIDTH-1:0]	base2,
	input	logic						done,		// Last beat of the transfer
	output	logic						grant1,
	output	logic						grant2,
	output	logic						start,		// Pulses in the first cycle of a grant
	output	logic	[ADDR_WIDTH-1:0]	length,
	output	logic	[ADDR_WIDTH-1:0]	stride,
	output	logic	[ADDR_WIDTH-1:0]	base
);
	import dmem_pkg::*;

	arb_state_e					state;
	logic						prio2;		// Requester 2 wins a tie
	logic						pick1;
	logic						pick2;
	logic						issue;		// Grant decision this cycle

	////////////////////////////////////////////////////////////
	// Round-robin choice
	////////////////////////////////////////////////////////////

	// Requester 1 takes a tie unless it was served last
	assign pick1	= req1 & ( ~req2 | ~prio2 );
	assign pick2	= req2 & ~pick1;
	assign issue	= ( state == ARB_IDLE ) & ( req1 | req2 );

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			state	<= ARB_IDLE;
			grant1	<= 1'b0;
			grant2	<= 1'b0;
			start	<= 1'b0;
			prio2	<= 1'b0;		// Requester 1 first after reset
		end
		else begin
			start	<= issue;
			case ( state )
				ARB_IDLE: begin
					if ( issue ) begin
						state	<= ARB_BUSY;
						grant1	<= pick1;
						grant2	<= pick2;
						prio2	<= pick1;		// Other side goes first next time
					end
				end
				ARB_BUSY: begin
					// Back to idle for at least one cycle
					if ( done ) begin
						state	<= ARB_IDLE;
						grant1	<= 1'b0;
						grant2	<= 1'b0;
					end
				end
				default: begin
					state	<= ARB_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Descriptor latch
	////////////////////////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( issue ) begin
			length	<= ( pick1 ) ? length1 : length2;
			stride	<= ( pick1 ) ? stride1 : stride2;
			base	<= ( pick1 ) ? base1 : base2;
		end
	end

endmodule

// ==== verilog/stride_agu.sv ====
// Length must be nonzero and addresses wrap modulo the memory size
module stride_agu #(
	parameter int ADDR_WIDTH	= dmem_pkg::DEFAULT_ADDR_WIDTH
) (
	input	logic						clock,
	input	logic						reset,
	input	logic						start,		// Load descriptor
	input	logic	[ADDR_WIDTH-1:0]	length,		// Beats in the transfer
	input	logic	[ADDR_WIDTH-1:0]	stride,
	input	logic	[ADDR_WIDTH-1:0]	base,
	input	logic						grant1,
	input	logic						grant2,
	input	logic						valid1,
	input	logic						valid2,
	input	logic						stall,		// Global freeze
	output	logic						ready1,
	output	logic						ready2,
	output	logic	[ADDR_WIDTH-1:0]	address,	// Address of the current beat
	output	logic						beat,		// Beat accepted
	output	logic						done		// Final beat accepted
);
	import dmem_pkg::*;

	agu_state_e					state;
	logic	[ADDR_WIDTH-1:0]	remaining;	// Beats still to accept
	logic						running;
	logic						valid;		// Valid of the granted requester

	////////////////////////////////////////////////////////////
	// Handshake
	////////////////////////////////////////////////////////////

	assign running	= ( state == AGU_RUN );
	assign valid	= ( grant1 & valid1 ) | ( grant2 & valid2 );

	// Ready stays up through stall
	assign ready1	= grant1 & running;
	assign ready2	= grant2 & running;

	assign beat		= running & valid & ~stall;
	assign done		= beat & ( remaining == ADDR_WIDTH'(1) );

	////////////////////////////////////////////////////////////
	// Beat counter and state
	////////////////////////////////////////////////////////////

	always_ff @( posedge clock ) begin
		if ( reset ) begin
			state		<= AGU_IDLE;
			remaining	<= '0;
		end
		else begin
			case ( state )
				AGU_IDLE: begin
					if ( start ) begin
						state		<= AGU_RUN;
						remaining	<= length;
					end
				end
				AGU_RUN: begin
					if ( beat ) begin
						remaining	<= remaining - ADDR_WIDTH'(1);
					end
					if ( done ) begin
						state		<= AGU_IDLE;	// Arbiter drops grant at the same edge
					end
				end
				default: begin
					state		<= AGU_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Running address
	////////////////////////////////////////////////////////////

	// Sum wraps at the address width
	always_ff @( posedge clock ) begin
		if ( start ) begin
			address		<= base;
		end
		else if ( beat ) begin
			address		<= address + stride;
		end
	end

endmodule
